// File: compile.f
src/exec_pkg.sv
src/dispatch_if.sv
src/fu_result_if.sv
src/reservation_station.sv
src/alu_unit.sv
src/mult_pipe.sv
src/cdb_arbiter.sv
src/exec_top.sv
sim/exec_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = exec_tb
FILELIST = compile.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/exec_trace.txt
# op dest expected a_ready a_value_or_tag b_ready b_value_or_tag
# numbers in hex and a ready flag of 0 makes the next column a producer tag
add    01 0000000c 1 00000005 1 00000007
sub    02 fffffffe 1 00000003 1 00000005
and    03 00f0f000 1 f0f0ff00 1 0ff0f0f0
or     04 12345678 1 12340000 1 00005678
xor    05 55555555 1 aaaa5555 1 ffff0000
sll    06 00000010 1 00000001 1 00000024
srl    07 00000001 1 80000000 1 0000001f
sra    08 f8000000 1 80000000 1 00000004
slt    09 00000001 1 ffffffff 1 00000001
sltu   0a 00000000 1 ffffffff 1 00000001
mul    0b ffffffeb 1 fffffffd 1 00000007
mulh   0c f0000000 1 c0000000 1 40000000
mulhsu 0d ffffffff 1 ffffffff 1 00000010
mulhu  0e fffffffe 1 ffffffff 1 ffffffff
mul    10 0000000f 1 00000003 1 00000005
add    11 00000010 0 10       1 00000001
mul    12 000000f0 0 11       0 10
mul    20 00000006 1 00000002 1 00000003
mul    21 0000000c 0 20       1 00000002
mul    22 00000018 0 21       1 00000002
add    23 00000019 0 22       1 00000001
xor    24 000000e7 0 22       1 000000ff
sll    25 00000180 0 22       1 00000004
srl    26 00000003 0 22       1 00000003
sub    27 ffffffe8 1 00000000 0 22

// File: sim/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    localparam int XLEN       = exec_pkg::XLEN_DEFAULT;
    localparam int TAG_W      = exec_pkg::TAG_W_DEFAULT;
    localparam int N_TAGS     = 1 << TAG_W;
    localparam int MUL_STAGES = 3;      // exec_top default
    localparam int MAX_LINES  = 64;

    logic               clock = 1'b0;
    logic               reset;
    logic               disp_valid;
    exec_pkg::exec_op_e disp_op;
    logic [TAG_W-1:0]   disp_dest_tag;
    logic               disp_opa_ready;
    logic [TAG_W-1:0]   disp_opa_tag;
    logic [XLEN-1:0]    disp_opa_value;
    logic               disp_opb_ready;
    logic [TAG_W-1:0]   disp_opb_tag;
    logic [XLEN-1:0]    disp_opb_value;
    logic               rs_alu_full;
    logic               rs_mul_full;
    logic               cdb_valid;
    logic [TAG_W-1:0]   cdb_tag;
    logic [XLEN-1:0]    cdb_value;

    // trace contents with bit 0 of tr_rdy as operand a
    exec_pkg::exec_op_e tr_op   [MAX_LINES];
    logic [TAG_W-1:0]   tr_dest [MAX_LINES];
    logic [XLEN-1:0]    tr_exp  [MAX_LINES];
    logic [1:0]         tr_rdy  [MAX_LINES];
    logic [XLEN-1:0]    tr_a    [MAX_LINES];
    logic [XLEN-1:0]    tr_b    [MAX_LINES];
    int                 n_lines = 0;

    // scoreboard keyed by destination tag
    logic [XLEN-1:0]    exp_value [N_TAGS];
    logic [N_TAGS-1:0]  expected = '0;
    logic [N_TAGS-1:0]  seen     = '0;
    int                 n_seen   = 0;

    int  value_errors = 0;
    int  tag_errors   = 0;
    int  reset_errors = 0;
    int  trace_errors = 0;
    int  full_errors  = 0;
    int  full_waits   = 0;
    int  cycle_count  = 0;
    int  cycle_limit  = 0;  // set once the trace is read
    logic reset_window  = 1'b0;
    logic mul_full_seen = 1'b0;

    exec_top u_exec_top (.*);

    always #4 clock = ~clock;   // 8 ns period

    function automatic logic parse_op(input string name, output exec_pkg::exec_op_e op);
        logic known;
        known = 1'b1;
        op    = exec_pkg::op_add;
        case (name)
            "add":    op = exec_pkg::op_add;
            "sub":    op = exec_pkg::op_sub;
            "and":    op = exec_pkg::op_and;
            "or":     op = exec_pkg::op_or;
            "xor":    op = exec_pkg::op_xor;
            "sll":    op = exec_pkg::op_sll;
            "srl":    op = exec_pkg::op_srl;
            "sra":    op = exec_pkg::op_sra;
            "slt":    op = exec_pkg::op_slt;
            "sltu":   op = exec_pkg::op_sltu;
            "mul":    op = exec_pkg::op_mul;
            "mulh":   op = exec_pkg::op_mulh;
            "mulhsu": op = exec_pkg::op_mulhsu;
            "mulhu":  op = exec_pkg::op_mulhu;
            default:  known = 1'b0;
        endcase
        return known;
    endfunction

    task automatic print_counts();
        $display({"errors: value %0d tag %0d reset %0d trace %0d full %0d,",
                  " results %0d of %0d, full waits %0d"},
                 value_errors, tag_errors, reset_errors, trace_errors, full_errors,
                 n_seen, n_lines, full_waits);
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("FAILED %s = %h, expected 0 around reset", name, value);
            reset_errors++;
        end
    endtask

    // called just after a rising edge and returns the same way
    task automatic dispatch_line(input int i);
        logic [1:0]      rdy;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            to_mul;
        to_mul = (exec_pkg::op_class(tr_op[i]) == exec_pkg::fu_mul);
        while (to_mul ? rs_mul_full : rs_alu_full) begin
            full_waits++;
            @(posedge clock);
            #1;
        end
        rdy = tr_rdy[i];
        a   = tr_a[i];
        b   = tr_b[i];
        // producer already broadcast so the register file would hold it
        if (!rdy[0] && seen[a[TAG_W-1:0]]) begin
            rdy[0] = 1'b1;
            a      = exp_value[a[TAG_W-1:0]];
        end
        if (!rdy[1] && seen[b[TAG_W-1:0]]) begin
            rdy[1] = 1'b1;
            b      = exp_value[b[TAG_W-1:0]];
        end
        exp_value[tr_dest[i]] = tr_exp[i];
        expected[tr_dest[i]]  = 1'b1;
        disp_valid     = 1'b1;
        disp_op        = tr_op[i];
        disp_dest_tag  = tr_dest[i];
        disp_opa_ready = rdy[0];
        disp_opa_tag   = rdy[0] ? '0 : a[TAG_W-1:0];
        disp_opa_value = rdy[0] ? a : '0;
        disp_opb_ready = rdy[1];
        disp_opb_tag   = rdy[1] ? '0 : b[TAG_W-1:0];
        disp_opb_value = rdy[1] ? b : '0;
        @(posedge clock);
        #1;
        disp_valid = 1'b0;
    endtask

    ////////////////////
    // monitors
    ////////////////////

    always @(negedge clock) begin
        if (reset_window) begin
            check_low("rs_alu_full", rs_alu_full);
            check_low("rs_mul_full", rs_mul_full);
            check_low("cdb_valid", cdb_valid);
        end
    end

    always @(negedge clock) begin
        if (!reset && rs_mul_full === 1'b1) mul_full_seen = 1'b1;   // no mul dispatch waits on it
    end

    always @(negedge clock) begin
        if (!reset && cdb_valid === 1'b1) begin
            assert (expected[cdb_tag]) else begin
                $display("broadcast of tag %h that no dispatch produced", cdb_tag);
                tag_errors++;
            end
            if (expected[cdb_tag]) begin
                assert (!seen[cdb_tag]) else begin
                    $display("tag %h broadcast more than once", cdb_tag);
                    tag_errors++;
                end
                assert (cdb_value === exp_value[cdb_tag]) else begin
                    $display("FAILED cdb_value = %h, expected %h, tag %h",
                             cdb_value, exp_value[cdb_tag], cdb_tag);
                    value_errors++;
                end
                if (!seen[cdb_tag]) n_seen++;
                seen[cdb_tag] = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with results still missing", cycle_count);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int              fd;
        int              code;
        int              gap;
        string           line;
        string           name;
        logic [31:0]     dest, expv, ardy, aval, brdy, bval;
        exec_pkg::exec_op_e op;
        void'($urandom(25157));
        reset          = 1'b1;
        disp_valid     = 1'b0;
        disp_op        = exec_pkg::op_add;
        disp_dest_tag  = '0;
        disp_opa_ready = 1'b0;
        disp_opa_tag   = '0;
        disp_opa_value = '0;
        disp_opb_ready = 1'b0;
        disp_opb_tag   = '0;
        disp_opb_value = '0;

        fd = $fopen("sim/exec_trace.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the trace file sim/exec_trace.txt");
            trace_errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;   // header or blank
            code = $sscanf(line, "%s %h %h %h %h %h %h", name, dest, expv, ardy, aval, brdy, bval);
            assert (code == 7 && parse_op(name, op) && n_lines < MAX_LINES) else begin
                $display("unreadable trace line: %s", line);
                trace_errors++;
                continue;
            end
            tr_op[n_lines]   = op;
            tr_dest[n_lines] = dest[TAG_W-1:0];
            tr_exp[n_lines]  = expv;
            tr_rdy[n_lines]  = {brdy[0], ardy[0]};
            tr_a[n_lines]    = aval;
            tr_b[n_lines]    = bval;
            n_lines++;
        end
        if (fd != 0) $fclose(fd);
        cycle_limit = n_lines * (MUL_STAGES + 8) + 100;

        // 4 cycles of reset with flags watched from the first edge
        @(posedge clock);
        reset_window = 1'b1;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        @(posedge clock);
        #1 reset_window = 1'b0;

        for (int i = 0; i < n_lines; i++) begin
            dispatch_line(i);
            gap = int'($urandom % 4);
            // waiting consumers follow back to back so the stations back up
            if (i + 1 < n_lines && tr_rdy[i+1] != 2'b11) gap = 0;
            repeat (gap) begin
                @(posedge clock);
                #1;
            end
        end

        while (n_seen < n_lines) @(posedge clock);
        repeat (MUL_STAGES + 8) @(posedge clock);  // room for a stray extra broadcast

        assert (full_waits > 0) else begin
            $display("no dispatch ever had to wait on a full station");
            full_errors++;
        end
        assert (mul_full_seen) else begin
            $display("mul station full flag never went high");
            full_errors++;
        end

        print_counts();
        if (value_errors + tag_errors + reset_errors + trace_errors + full_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src/exec_top.sv
`timescale 1ns/1ps

module exec_top #(
    parameter int XLEN         = exec_pkg::XLEN_DEFAULT,
    parameter int TAG_W        = exec_pkg::TAG_W_DEFAULT,
    parameter int ALU_RS_DEPTH = 4,
    parameter int MUL_RS_DEPTH = 2,
    parameter int MUL_STAGES   = 3
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               disp_valid,
    input  exec_pkg::exec_op_e disp_op,
    input  logic [TAG_W-1:0]   disp_dest_tag,
    input  logic               disp_opa_ready,
    input  logic [TAG_W-1:0]   disp_opa_tag,
    input  logic [XLEN-1:0]    disp_opa_value,
    input  logic               disp_opb_ready,
    input  logic [TAG_W-1:0]   disp_opb_tag,
    input  logic [XLEN-1:0]    disp_opb_value,
    output logic               rs_alu_full,
    output logic               rs_mul_full,
    output logic               cdb_valid,
    output logic [TAG_W-1:0]   cdb_tag,
    output logic [XLEN-1:0]    cdb_value
);
    exec_pkg::fu_class_e disp_class;

    // index 0 feeds the alu station and index 1 the mul station
    dispatch_if  #(.XLEN(XLEN), .TAG_W(TAG_W)) disp_bus [2] ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) alu_res ();
    fu_result_if #(.XLEN(XLEN), .TAG_W(TAG_W)) mul_res ();

    // station to unit issue wires
    logic               alu_iss_valid, mul_iss_valid;
    exec_pkg::exec_op_e alu_iss_op, mul_iss_op;
    logic [XLEN-1:0]    alu_iss_a, alu_iss_b, mul_iss_a, mul_iss_b;
    logic [TAG_W-1:0]   alu_iss_tag, mul_iss_tag;
    logic               alu_ready;

    ////////////////////
    // dispatch split
    ////////////////////

    assign disp_class = exec_pkg::op_class(disp_op);

    for (genvar g = 0; g < 2; g++) begin : g_route
        // valid only toward the station of its class
        assign disp_bus[g].valid     = disp_valid && (disp_class == exec_pkg::fu_class_e'(g));
        assign disp_bus[g].op        = disp_op;
        assign disp_bus[g].dest_tag  = disp_dest_tag;
        assign disp_bus[g].opa_ready = disp_opa_ready;
        assign disp_bus[g].opa_tag   = disp_opa_tag;
        assign disp_bus[g].opa_value = disp_opa_value;
        assign disp_bus[g].opb_ready = disp_opb_ready;
        assign disp_bus[g].opb_tag   = disp_opb_tag;
        assign disp_bus[g].opb_value = disp_opb_value;
    end

    ////////////////////
    // alu cluster
    ////////////////////

    reservation_station #(.DEPTH(ALU_RS_DEPTH), .XLEN(XLEN), .TAG_W(TAG_W)) u_rs_alu (
        .clock(clock), .reset(reset), .disp(disp_bus[0]),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .unit_ready(alu_ready),     // back-pressure from the held result
        .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_a(alu_iss_a), .issue_b(alu_iss_b), .issue_tag(alu_iss_tag),
        .full(rs_alu_full)
    );

    alu_unit #(.XLEN(XLEN), .TAG_W(TAG_W)) u_alu (
        .clock(clock), .reset(reset),
        .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_a(alu_iss_a), .issue_b(alu_iss_b), .issue_tag(alu_iss_tag),
        .unit_ready(alu_ready), .res(alu_res)
    );

    ////////////////////
    // mul cluster
    ////////////////////

    reservation_station #(.DEPTH(MUL_RS_DEPTH), .XLEN(XLEN), .TAG_W(TAG_W)) u_rs_mul (
        .clock(clock), .reset(reset), .disp(disp_bus[1]),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .unit_ready(1'b1),          // pipe takes one every cycle
        .issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
        .issue_a(mul_iss_a), .issue_b(mul_iss_b), .issue_tag(mul_iss_tag),
        .full(rs_mul_full)
    );

    mult_pipe #(.XLEN(XLEN), .TAG_W(TAG_W), .MUL_STAGES(MUL_STAGES)) u_mult (
        .clock(clock), .reset(reset),
        .issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
        .issue_a(mul_iss_a), .issue_b(mul_iss_b), .issue_tag(mul_iss_tag),
        .res(mul_res)
    );

    cdb_arbiter #(.XLEN(XLEN), .TAG_W(TAG_W)) u_cdb (
        .alu(alu_res), .mul(mul_res),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

endmodule

// File: src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
) (
    fu_result_if.arb         alu,
    fu_result_if.arb         mul,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0]  cdb_value
);

    // mul pipe cannot hold a result so it always wins
    assign mul.grant = 1'b1;
    assign alu.grant = alu.valid && !mul.valid;     // alu waits in its output reg

    always_comb begin
        if (mul.valid) begin
            cdb_valid = 1'b1;
            cdb_tag   = mul.tag;
            cdb_value = mul.value;
        end else begin
            cdb_valid = alu.valid;
            cdb_tag   = alu.tag;
            cdb_value = alu.value;
        end
    end

endmodule

// File: src/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe #(
    parameter int XLEN       = 32,
    parameter int TAG_W      = 6,
    parameter int MUL_STAGES = 3
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_valid,
    input  exec_pkg::exec_op_e issue_op,
    input  logic [XLEN-1:0]    issue_a,
    input  logic [XLEN-1:0]    issue_b,
    input  logic [TAG_W-1:0]   issue_tag,
    fu_result_if.unit          res
);
    localparam int PW = 2 * XLEN;

    logic            a_signed;
    logic            b_signed;
    logic [PW-1:0]   a_ext;
    logic [PW-1:0]   b_ext;
    logic [PW-1:0]   product;
    logic [XLEN-1:0] word;

    // pipeline registers
    logic [MUL_STAGES-1:0] st_valid;
    logic [TAG_W-1:0]      st_tag   [MUL_STAGES];
    logic [XLEN-1:0]       st_value [MUL_STAGES];

    ////////////////////
    // first stage
    ////////////////////

    always_comb begin
        a_signed = (issue_op == exec_pkg::op_mulh) || (issue_op == exec_pkg::op_mulhsu);
        b_signed = (issue_op == exec_pkg::op_mulh);
        // extend to full width so one unsigned multiply covers every variant
        a_ext    = {{XLEN{a_signed & issue_a[XLEN-1]}}, issue_a};
        b_ext    = {{XLEN{b_signed & issue_b[XLEN-1]}}, issue_b};
        product  = a_ext * b_ext;   // low PW bits only
        word     = (issue_op == exec_pkg::op_mul) ? product[XLEN-1:0] : product[PW-1:XLEN];
    end

    ////////////////////
    // shift down the pipe
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            st_valid <= '0;
        end else begin
            st_valid[0] <= issue_valid;
            for (int i = 1; i < MUL_STAGES; i++) begin
                st_valid[i] <= st_valid[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        st_tag[0]   <= issue_tag;
        st_value[0] <= word;
        for (int i = 1; i < MUL_STAGES; i++) begin
            st_tag[i]   <= st_tag[i-1];
            st_value[i] <= st_value[i-1];
        end
    end

    // grant is never refused so the pipe never stalls
    assign res.valid = st_valid[MUL_STAGES-1];
    assign res.tag   = st_tag[MUL_STAGES-1];
    assign res.value = st_value[MUL_STAGES-1];

endmodule

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_valid,
    input  exec_pkg::exec_op_e issue_op,
    input  logic [XLEN-1:0]    issue_a,
    input  logic [XLEN-1:0]    issue_b,
    input  logic [TAG_W-1:0]   issue_tag,
    output logic               unit_ready,
    fu_result_if.unit          res
);
    localparam int SHAMT_W = $clog2(XLEN);  // 5 bits at 32

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;
    logic               out_valid;  // result waiting for the cdb
    logic [TAG_W-1:0]   out_tag;
    logic [XLEN-1:0]    out_value;

    assign shamt = issue_b[SHAMT_W-1:0];

    always_comb begin
        case (issue_op)
            exec_pkg::op_add:  result = issue_a + issue_b;
            exec_pkg::op_sub:  result = issue_a - issue_b;
            exec_pkg::op_and:  result = issue_a & issue_b;
            exec_pkg::op_or:   result = issue_a | issue_b;
            exec_pkg::op_xor:  result = issue_a ^ issue_b;
            exec_pkg::op_sll:  result = issue_a << shamt;
            exec_pkg::op_srl:  result = issue_a >> shamt;
            exec_pkg::op_sra:  result = $signed(issue_a) >>> shamt;
            exec_pkg::op_slt:  result = XLEN'($signed(issue_a) < $signed(issue_b));
            exec_pkg::op_sltu: result = XLEN'(issue_a < issue_b);
            default:           result = '0;    // mul ops never reach here
        endcase
    end

    // free when empty or handing off this cycle
    assign unit_ready = !out_valid || res.grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (issue_valid && unit_ready) begin
            out_valid <= 1'b1;
        end else if (res.grant) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid && unit_ready) begin
            out_tag   <= issue_tag;
            out_value <= result;
        end
    end

    assign res.valid = out_valid;
    assign res.tag   = out_tag;
    assign res.value = out_value;

endmodule

// File: src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int DEPTH = 4,
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
) (
    input  logic               clock,
    input  logic               reset,
    dispatch_if.rs             disp,
    input  logic               cdb_valid,
    input  logic [TAG_W-1:0]   cdb_tag,
    input  logic [XLEN-1:0]    cdb_value,
    input  logic               unit_ready,
    output logic               issue_valid,
    output exec_pkg::exec_op_e issue_op,
    output logic [XLEN-1:0]    issue_a,
    output logic [XLEN-1:0]    issue_b,
    output logic [TAG_W-1:0]   issue_tag,
    output logic               full
);
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // slot 0 holds operand a and slot 1 operand b
    logic [DEPTH-1:0]   ent_valid;
    exec_pkg::exec_op_e ent_op   [DEPTH];
    logic [TAG_W-1:0]   ent_dest [DEPTH];
    logic [1:0]         ent_rdy  [DEPTH];
    logic [TAG_W-1:0]   ent_tag  [DEPTH][2];
    logic [XLEN-1:0]    ent_val  [DEPTH][2];

    logic [DEPTH-1:0]   req;            // entry has both operands
    logic [IDX_W-1:0]   free_idx;       // lowest empty entry
    logic [IDX_W-1:0]   iss_idx;        // lowest ready entry
    logic               disp_accept;
    logic [DEPTH-1:0]   valid_next;

    // incoming operands after cdb bypass
    logic [1:0]         src_rdy;
    logic [TAG_W-1:0]   src_tag [2];
    logic [XLEN-1:0]    src_val [2];

    ////////////////////
    // dispatch side
    ////////////////////

    always_comb begin
        src_rdy[0] = disp.opa_ready;
        src_rdy[1] = disp.opb_ready;
        src_tag[0] = disp.opa_tag;
        src_tag[1] = disp.opb_tag;
        src_val[0] = disp.opa_value;
        src_val[1] = disp.opb_value;
        for (int s = 0; s < 2; s++) begin
            // producer broadcasting right now
            if (!src_rdy[s] && cdb_valid && (cdb_tag == src_tag[s])) begin
                src_rdy[s] = 1'b1;
                src_val[s] = cdb_value;
            end
        end
    end

    assign disp_accept = disp.valid && !full;   // dropped when full

    ////////////////////
    // select
    ////////////////////

    always_comb begin
        free_idx = '0;
        iss_idx  = '0;
        // walk down so the lowest index is written last
        for (int i = DEPTH - 1; i >= 0; i--) begin
            req[i] = ent_valid[i] && (&ent_rdy[i]);
            if (!ent_valid[i]) free_idx = IDX_W'(i);
            if (req[i]) iss_idx = IDX_W'(i);
        end
    end

    assign issue_valid = (|req) && unit_ready;
    assign issue_op    = ent_op[iss_idx];
    assign issue_a     = ent_val[iss_idx][0];
    assign issue_b     = ent_val[iss_idx][1];
    assign issue_tag   = ent_dest[iss_idx];

    always_comb begin
        valid_next = ent_valid;
        if (issue_valid) valid_next[iss_idx] = 1'b0;
        if (disp_accept) valid_next[free_idx] = 1'b1;
    end

    ////////////////////
    // state
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            full      <= 1'b0;
        end else begin
            ent_valid <= valid_next;
            full      <= &valid_next;   // drops a cycle after issue frees one
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < DEPTH; i++) begin
            // wakeup of waiting slots
            for (int s = 0; s < 2; s++) begin
                if (ent_valid[i] && !ent_rdy[i][s] && cdb_valid
                        && (cdb_tag == ent_tag[i][s])) begin
                    ent_rdy[i][s] <= 1'b1;
                    ent_val[i][s] <= cdb_value;
                end
            end
            if (disp_accept && (free_idx == IDX_W'(i))) begin
                ent_op[i]   <= disp.op;
                ent_dest[i] <= disp.dest_tag;
                ent_rdy[i]  <= src_rdy;
                for (int s = 0; s < 2; s++) begin
                    ent_tag[i][s] <= src_tag[s];
                    ent_val[i][s] <= src_val[s];
                end
            end
        end
    end

endmodule

// File: src/fu_result_if.sv
`timescale 1ns/1ps

// unit result toward the cdb arbiter
interface fu_result_if #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
);
    logic             valid;
    logic [TAG_W-1:0] tag;      // destination tag to broadcast
    logic [XLEN-1:0]  value;
    logic             grant;    // arbiter took it this cycle

    modport unit (output valid, tag, value, input grant);

    modport arb (input valid, tag, value, output grant);
endinterface

// File: src/dispatch_if.sv
`timescale 1ns/1ps

// one renamed instruction headed for a station
interface dispatch_if #(
    parameter int XLEN  = 32,
    parameter int TAG_W = 6
);
    logic               valid;
    exec_pkg::exec_op_e op;
    logic [TAG_W-1:0]   dest_tag;   // physical destination
    logic               opa_ready;  // value present when set
    logic [TAG_W-1:0]   opa_tag;    // producer tag when not ready
    logic [XLEN-1:0]    opa_value;
    logic               opb_ready;
    logic [TAG_W-1:0]   opb_tag;
    logic [XLEN-1:0]    opb_value;

    modport src (
        output valid, op, dest_tag, opa_ready, opa_tag, opa_value,
               opb_ready, opb_tag, opb_value
    );

    modport rs (
        input valid, op, dest_tag, opa_ready, opa_tag, opa_value,
              opb_ready, opb_tag, opb_value
    );
endinterface

// File: src/exec_pkg.sv
package exec_pkg;

    // default widths for the top level parameters
    localparam int XLEN_DEFAULT  = 32;
    localparam int TAG_W_DEFAULT = 6;   // 64 physical registers

    // opcodes seen at dispatch
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_xor    = 4'd4,
        op_sll    = 4'd5,
        op_srl    = 4'd6,
        op_sra    = 4'd7,
        op_slt    = 4'd8,
        op_sltu   = 4'd9,
        op_mul    = 4'd10,  // low word
        op_mulh   = 4'd11,  // signed x signed high word
        op_mulhsu = 4'd12,  // signed x unsigned high word
        op_mulhu  = 4'd13   // unsigned x unsigned high word
    } exec_op_e;

    // which station and unit take the op
    typedef enum logic [0:0] {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_class_e;

    function automatic fu_class_e op_class(input exec_op_e op);
        case (op)
            op_mul, op_mulh, op_mulhsu, op_mulhu: return fu_mul;
            default:                              return fu_alu;
        endcase
    endfunction

endpackage
